/* bench/cpuPatterns.txt */
// columns: type(1) addr(3) data(4) in hex
// type 1 program word, 2 data memory byte, 3 expected store in order
10000C5A // LDCA 5A
100110C3 // LDCB C3
10021500 // STA 100
10031901 // STB 101
10040480 // LDA 080
10050881 // LDB 081
10061502
10071903
10081C00 // ADDA, dependent store follows
10091504
100A2000 // ADDB
100B1905
100C2440 // ADDCA 40
100D28F0 // ADDCB F0
100E1506
100F1907
10102C00 // SUBA
10113000 // SUBB
10121508
10131909
10143433 // SUBCA 33
10153850 // SUBCB 50
1016150A
1017190B
1018103C // LDCB 3C
10193C00 // ANDA
101A5481 // ORCA 81
101B480F // ANDCB 0F
101C150C
101D190D
101E5000 // ORB
101F190E
10200C96 // LDCA 96
10214000 // ANDB
10224C00 // ORA
10235821 // ORCB 21
1024150F
10251910
10260C81 // LDCA 81
10275C00 // ASLA
10281511
10290C81
102A6000 // ASRA
102B1512
102C6801 // BAEQ +1 not taken
102D6C01 // BANE +1 taken
102E15FF
102F7001 // BAMI +1 not taken
10307401 // BAPL +1 taken
103115FF
10327801 // BBEQ +1 not taken
10337C01 // BBNE +1 taken
103419FF
10358001 // BBMI +1 taken
103619FF
10378401 // BBPL +1 not taken
10381513
10390C00 // LDCA 00
103A6802 // BAEQ +2 taken
103B15FF
103C15FF
103D6441 // JMP 041
103E15FF
103F1514
10406443 // JMP 043
10417423 // BAPL -3 back to 03F
104215FF
10431915
10446444 // JMP to itself
20800037
2081009E
3100005A
310100C3
31020037
3103009E
310400D5
31050073
31060015
31070063
310800B2
3109004F
310A007F
310B00FF
310C00BD
310D000C
310E00BD
310F0096
311000B5
31110002
31120040
31130040
31140000
311500B5

/* all.f */
verilog/cpuPkg.sv
verilog/ctrlIf.sv
verilog/alu.sv
verilog/ex.sv
verilog/decode.sv
verilog/fetch.sv
verilog/pipeCtrl.sv
verilog/pipeReg.sv
verilog/cpuTop.sv
bench/cpuTop_chk.sv
bench/cpuTb.sv

/* run.sh */
#!/bin/bash
# build and run the cpuTb simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f all.f --top-module cpuTb -o simCpu > build.log 2>&1 \
	&& ./obj_dir/simCpu > sim.log 2>&1 \
	|| echo "FAIL: see errors above" >> sim.log
cat build.log sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

/* bench/cpuTb.sv */
`timescale 1ns/100ps

module cpuTb;
	import cpuPkg::*;

	localparam int dataW = 8;
	localparam int addrW = 10;
	localparam int memDepth = 1 << addrW;
	localparam int patDepth = 256;
	localparam int resetCycles = 16;
	// quiet cycles after the last expected store to catch stray stores
	localparam int drainCycles = 40;

	logic clk;
	logic arstN;
	logic [addrW-1:0] instrAddr;
	logic [instrW-1:0] instrData;
	logic [addrW-1:0] dataAddr;
	logic dataRd;
	logic dataWr;
	logic [dataW-1:0] dataWrData;
	logic [dataW-1:0] dataRdData;

	// pattern records with the type in the top nibble
	logic [31:0] patMem [patDepth];
	logic [instrW-1:0] instrMem [memDepth];
	logic [dataW-1:0] dataMem [memDepth];
	logic [addrW-1:0] expAddr [$];
	logic [dataW-1:0] expData [$];
	// byte fetched for the load now in EX
	logic [dataW-1:0] rdPend;
	int errors;
	int storesSeen;
	int progWords;

	cpuTop #(
		.dataW(dataW),
		.addrW(addrW),
		.resetPc(0)
	) u_cpuTop (
		.clk(clk),
		.arstN(arstN),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.dataAddr(dataAddr),
		.dataRd(dataRd),
		.dataWr(dataWr),
		.dataWrData(dataWrData),
		.dataRdData(dataRdData)
	);

	bind cpuTop cpuTop_chk uChk (
		.clk(clk),
		.arstN(arstN),
		.dataRd(dataRd),
		.dataWr(dataWr),
		.dataAddr(dataAddr),
		.stall(ctrlBus.stall)
	);

	// combinational instruction memory
	assign instrData = instrMem[instrAddr];

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic loadPatterns;
		logic [3:0] kind;
		logic [11:0] addr;
		logic [15:0] word;
		// unused words jump to themselves
		// data bytes follow the address
		for (int i = 0; i < memDepth; i++) begin
			instrMem[i] = {JMP, 10'(i)};
			dataMem[i] = 8'(i) ^ 8'(i >> 2);
		end
		for (int i = 0; i < patDepth; i++) begin
			patMem[i] = '0;
		end
		$readmemh("bench/cpuPatterns.txt", patMem);
		for (int i = 0; i < patDepth; i++) begin
			{kind, addr, word} = patMem[i];
			case (kind)
				4'h1: begin
					instrMem[addr[9:0]] = word;
					progWords++;
				end
				4'h2: dataMem[addr[9:0]] = word[7:0];
				4'h3: begin
					expAddr.push_back(addr[9:0]);
					expData.push_back(word[7:0]);
				end
				default: ;
			endcase
		end
	endtask

	task automatic checkIdle(input logic checkPc);
		assert (!dataWr) else begin
			errors++;
			$display("Fail %0t dataWr expected 0 got %b", $time, dataWr);
		end
		assert (!dataRd) else begin
			errors++;
			$display("Fail %0t dataRd expected 0 got %b", $time, dataRd);
		end
		if (checkPc) begin
			assert (instrAddr == addrW'(0)) else begin
				errors++;
				$display("Fail %0t instrAddr expected %h got %h", $time, addrW'(0), instrAddr);
			end
		end
	endtask

	task automatic checkStore;
		logic [addrW-1:0] a;
		logic [dataW-1:0] d;
		storesSeen++;
		assert (expAddr.size() != 0) else begin
			errors++;
			$display("extra store of %h to address %h at %0t", dataWrData, dataAddr, $time);
		end
		if (expAddr.size() != 0) begin
			a = expAddr.pop_front();
			d = expData.pop_front();
			assert (dataAddr == a) else begin
				errors++;
				$display("Fail %0t dataAddr expected %h got %h", $time, a, dataAddr);
			end
			assert (dataWrData == d) else begin
				errors++;
				$display("Fail %0t dataWrData expected %h got %h", $time, d, dataWrData);
			end
		end
	endtask

	// data memory side runs on the falling edge
	always @(negedge clk) begin
		// read data shows up in the cycle after dataRd
		dataRdData = rdPend;
		if (arstN && dataRd) begin
			rdPend = dataMem[dataAddr];
		end
		if (arstN && dataWr) begin
			checkStore();
		end
	end

	initial begin
		arstN = 1'b1;
		dataRdData = '0;
		rdPend = '0;
		errors = 0;
		storesSeen = 0;
		progWords = 0;
		loadPatterns();
		#1 arstN = 1'b0;
		repeat (resetCycles) begin
			@(negedge clk);
			checkIdle(1'b1);
		end
		arstN = 1'b1;
		@(negedge clk);
		checkIdle(1'b0);
		while (expAddr.size() != 0) begin
			@(negedge clk);
		end
		repeat (drainCycles) @(negedge clk);
		$display("stores checked: %0d, errors: %0d", storesSeen, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog sized by the program length
	initial begin
		wait (arstN === 1'b0);
		@(posedge arstN);
		repeat (progWords * 20 + 200) @(posedge clk);
		errors++;
		$display("timeout, %0d expected stores never happened", expAddr.size());
		$display("stores checked: %0d, errors: %0d", storesSeen, errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* bench/cpuTop_chk.sv */
`timescale 1ns/100ps

module cpuTop_chk #(
	parameter int addrW = 10
) (
	input logic clk,
	input logic arstN,
	input logic dataRd,
	input logic dataWr,
	input logic [addrW-1:0] dataAddr,
	input logic stall
);

	// one memory access per cycle
	noRdWr: assert property (@(posedge clk) disable iff (!arstN) !(dataRd && dataWr))
		else $error("dataRd and dataWr high together");

	// store address must be driven
	wrAddrKnown: assert property (@(posedge clk) disable iff (!arstN)
		dataWr |-> !$isunknown(dataAddr))
		else $error("dataAddr unknown during store");

	// hazard stall is single cycle
	stallOnce: assert property (@(posedge clk) disable iff (!arstN) stall |=> !stall)
		else $error("stall held for two cycles");

	// pipeline empty right after reset release
	idleAfterReset: assert property (@(posedge clk) $rose(arstN) |-> (!dataRd && !dataWr))
		else $error("memory strobe right after reset");

endmodule

/* verilog/cpuTop.sv */
`timescale 1ns/100ps

module cpuTop #(
	parameter int dataW = 8,
	parameter int addrW = 10,
	parameter int resetPc = 0
) (
	input logic clk,
	input logic arstN,
	output logic [addrW-1:0] instrAddr,
	input logic [cpuPkg::instrW-1:0] instrData,
	output logic [addrW-1:0] dataAddr,
	output logic dataRd,
	output logic dataWr,
	output logic [dataW-1:0] dataWrData,
	input logic [dataW-1:0] dataRdData
);
	import cpuPkg::*;

	ifIdT ifIdD;
	ifIdT ifIdQ;
	logic ifIdValid;
	idExT idExD;
	idExT idExQ;
	exWbT exWbD;
	exWbT exWbQ;
	logic exWbValid;

	ctrlIf ctrlBus ();

	// fetched word tagged with its own address
	assign ifIdD = '{instruction: instrData, pc: instrAddr};
	assign ctrlBus.exAcumCtrl = exWbD.acumCtrl;

	pipeCtrl uPipeCtrl (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus)
	);

	fetch #(
		.addrW(addrW),
		.resetPc(resetPc)
	) uFetch (
		.clk(clk),
		.arstN(arstN),
		.ctrl(ctrlBus),
		.redirect(ctrlBus.branchTaken),
		.redirectAddr(idExQ.target),
		.instrAddr(instrAddr)
	);

	// IF/ID, held on stall
	pipeReg #(
		.payloadT(ifIdT)
	) uIfIdReg (
		.clk(clk),
		.arstN(arstN),
		.hold(ctrlBus.stall),
		.flush(ctrlBus.flushId),
		.dIn(ifIdD),
		.dValid(1'b1),
		.q(ifIdQ),
		.qValid(ifIdValid)
	);

	decode #(
		.dataW(dataW),
		.addrW(addrW)
	) uDecode (
		.clk(clk),
		.arstN(arstN),
		.ifId(ifIdQ),
		.wb(exWbQ),
		.wbValid(exWbValid),
		.dataRdData(dataRdData),
		.idOp(ctrlBus.idOp),
		.idEx(idExD)
	);

	// ID/EX, flushEx also carries the stall bubble
	pipeReg #(
		.payloadT(idExT)
	) uIdExReg (
		.clk(clk),
		.arstN(arstN),
		.hold(1'b0),
		.flush(ctrlBus.flushEx),
		.dIn(idExD),
		.dValid(ifIdValid),
		.q(idExQ),
		.qValid(ctrlBus.exValid)
	);

	ex #(
		.dataW(dataW),
		.addrW(addrW)
	) uEx (
		.idEx(idExQ),
		.exValid(ctrlBus.exValid),
		.redirect(ctrlBus.branchTaken),
		.exWb(exWbD),
		.dataAddr(dataAddr),
		.dataRd(dataRd),
		.dataWr(dataWr),
		.dataWrData(dataWrData)
	);

	// EX/WB, never stalled
	pipeReg #(
		.payloadT(exWbT)
	) uExWbReg (
		.clk(clk),
		.arstN(arstN),
		.hold(1'b0),
		.flush(1'b0),
		.dIn(exWbD),
		.dValid(ctrlBus.exValid),
		.q(exWbQ),
		.qValid(exWbValid)
	);

endmodule

/* verilog/pipeReg.sv */
`timescale 1ns/100ps

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic arstN,
	input logic hold,
	input logic flush,
	input payloadT dIn,
	input logic dValid,
	output payloadT q,
	output logic qValid
);

	// flush beats hold, hold beats load
	// payload cleared on reset so a zero opcode decodes as NOP
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
			qValid <= 1'b0;
		end else if (flush) begin
			qValid <= 1'b0;
		end else if (!hold) begin
			q <= dIn;
			qValid <= dValid;
		end
	end

endmodule

/* verilog/pipeCtrl.sv */
`timescale 1ns/100ps

module pipeCtrl (
	input logic clk,
	input logic arstN,
	ctrlIf.ctrl ctrl
);
	import cpuPkg::*;

	logic readsA;
	logic readsB;
	logic writesA;
	logic writesB;
	logic hazard;
	logic stalledQ;

	// accumulators the ID instruction reads
	assign readsA = ctrl.idOp inside {STA, ADDA, ADDB, SUBA, SUBB, ANDA, ANDB, ORA, ORB,
		ADDCA, SUBCA, ANDCA, ORCA, ASLA, ASRA, BAEQ, BANE, BAMI, BAPL};
	assign readsB = ctrl.idOp inside {STB, ADDA, ADDB, SUBA, SUBB, ANDA, ANDB, ORA, ORB,
		ADDCB, SUBCB, ANDCB, ORCB, BBEQ, BBNE, BBMI, BBPL};

	// accumulator the EX instruction will write in WB
	assign writesA = ctrl.exAcumCtrl inside {loadConstA, loadResultA, loadMemA};
	assign writesB = ctrl.exAcumCtrl inside {loadConstB, loadResultB, loadMemB};

	// one cycle later the producer is in WB and write-through covers it
	assign hazard = ctrl.exValid && ((readsA && writesA) || (readsB && writesB));
	assign ctrl.stall = hazard && !stalledQ;

	// taken branch kills ID and EX, a stall leaves a bubble in EX
	assign ctrl.flushId = ctrl.branchTaken;
	assign ctrl.flushEx = ctrl.branchTaken | ctrl.stall;

	// stall released after a single cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stalledQ <= 1'b0;
		end else begin
			stalledQ <= ctrl.stall;
		end
	end

endmodule

/* verilog/fetch.sv */
`timescale 1ns/100ps

module fetch #(
	parameter int addrW = 10,
	parameter int resetPc = 0
) (
	input logic clk,
	input logic arstN,
	ctrlIf.stage ctrl,
	input logic redirect,
	input logic [addrW-1:0] redirectAddr,
	output logic [addrW-1:0] instrAddr
);

	logic [addrW-1:0] pcQ;

	// redirect first, then stall hold, else next word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcQ <= addrW'(resetPc);
		end else if (redirect) begin
			pcQ <= redirectAddr;
		end else if (!ctrl.stall) begin
			pcQ <= pcQ + addrW'(1);
		end
	end

	// instruction memory answers combinationally on this address
	assign instrAddr = pcQ;

endmodule

/* verilog/decode.sv */
`timescale 1ns/100ps

module decode #(
	parameter int dataW = 8,
	parameter int addrW = 10
) (
	input logic clk,
	input logic arstN,
	input cpuPkg::ifIdT ifId,
	input cpuPkg::exWbT wb,
	input logic wbValid,
	input logic [dataW-1:0] dataRdData,
	output cpuPkg::opcodeT idOp,
	output cpuPkg::idExT idEx
);
	import cpuPkg::*;

	logic [dataW-1:0] acumAQ;
	logic [dataW-1:0] acumBQ;
	logic [dataW-1:0] wbData;
	logic wrA;
	logic wrB;
	opcodeT rawOp;
	opcodeT op;
	muxSelT muxSel;
	acumCtrlT acumCtrl;
	logic isStore;
	logic isLoad;
	logic [addrW-1:0] absAddr;
	logic [addrW-1:0] nextPc;
	logic [addrW-1:0] relTarget;
	logic [4:0] offMag;

	// opcode on top, 10 bits of info below
	assign rawOp = opcodeT'(ifId.instruction[15:10]);
	assign absAddr = ifId.instruction[addrW-1:0];

	// relative offset is sign-magnitude, bit 5 is the sign
	assign offMag = ifId.instruction[4:0];
	assign nextPc = ifId.pc + addrW'(1);
	assign relTarget = ifId.instruction[5] ? nextPc - addrW'(offMag) : nextPc + addrW'(offMag);

	always_comb begin
		op = rawOp;
		muxSel = selConstants;
		acumCtrl = noLoad;
		isStore = 1'b0;
		isLoad = 1'b0;
		case (rawOp)
			NOP, JMP: muxSel = selConstants;
			LDA: begin
				acumCtrl = loadMemA;
				isLoad = 1'b1;
			end
			LDB: begin
				acumCtrl = loadMemB;
				isLoad = 1'b1;
			end
			LDCA: acumCtrl = loadConstA;
			LDCB: acumCtrl = loadConstB;
			// both accumulators on the operands, ex picks the stored one
			STA, STB: begin
				muxSel = selAcumAB;
				isStore = 1'b1;
			end
			ADDA, SUBA, ANDA, ORA, ASLA, ASRA: begin
				muxSel = selAcumAB;
				acumCtrl = loadResultA;
			end
			ADDB, SUBB, ANDB, ORB: begin
				muxSel = selAcumAB;
				acumCtrl = loadResultB;
			end
			ADDCA, SUBCA, ANDCA, ORCA: begin
				muxSel = selAcumAConstB;
				acumCtrl = loadResultA;
			end
			ADDCB, SUBCB, ANDCB, ORCB: begin
				muxSel = selConstAAcumB;
				acumCtrl = loadResultB;
			end
			// alu needs the tested accumulator
			BAEQ, BANE, BAMI, BAPL, BBEQ, BBNE, BBMI, BBPL: muxSel = selAcumAB;
			default: op = NOP;
		endcase
	end

	// WB side, memory byte or alu result
	assign wrA = wbValid && (wb.acumCtrl inside {loadConstA, loadResultA, loadMemA});
	assign wrB = wbValid && (wb.acumCtrl inside {loadConstB, loadResultB, loadMemB});
	assign wbData = (wb.acumCtrl inside {loadMemA, loadMemB}) ? dataRdData : wb.result;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			acumAQ <= '0;
			acumBQ <= '0;
		end else begin
			if (wrA) acumAQ <= wbData;
			if (wrB) acumBQ <= wbData;
		end
	end

	assign idOp = op;

	always_comb begin
		// write-through so ID sees the byte being written this cycle
		idEx.acumA = wrA ? wbData : acumAQ;
		idEx.acumB = wrB ? wbData : acumBQ;
		idEx.constant = ifId.instruction[7:0];
		idEx.muxSel = muxSel;
		idEx.op = op;
		// absolute for jumps and memory access, else pc-relative
		idEx.target = (op inside {JMP, LDA, LDB, STA, STB}) ? absAddr : relTarget;
		idEx.acumCtrl = acumCtrl;
		idEx.isStore = isStore;
		idEx.isLoad = isLoad;
	end

endmodule

/* verilog/ex.sv */
`timescale 1ns/100ps

module ex #(
	parameter int dataW = 8,
	parameter int addrW = 10
) (
	input cpuPkg::idExT idEx,
	input logic exValid,
	output logic redirect,
	output cpuPkg::exWbT exWb,
	output logic [addrW-1:0] dataAddr,
	output logic dataRd,
	output logic dataWr,
	output logic [dataW-1:0] dataWrData
);
	import cpuPkg::*;

	logic [dataW-1:0] oper1;
	logic [dataW-1:0] oper2;
	logic [dataW-1:0] aluResult;
	logic aluBranch;

	// operand muxes, accumulator or the instruction constant
	assign oper1 = idEx.muxSel[0] ? idEx.acumA : idEx.constant;
	assign oper2 = idEx.muxSel[1] ? idEx.acumB : idEx.constant;

	alu #(
		.dataW(dataW)
	) aluEx (
		.oper1(oper1),
		.oper2(oper2),
		.op(idEx.op),
		.result(aluResult),
		.branchTaken(aluBranch)
	);

	// a bubble must not branch, write or touch memory
	assign redirect = exValid & aluBranch;
	assign exWb.result = aluResult;
	assign exWb.acumCtrl = exValid ? idEx.acumCtrl : noLoad;

	// one address field serves memory access and the branch target
	assign dataAddr = idEx.target;
	assign dataRd = exValid & idEx.isLoad;
	assign dataWr = exValid & idEx.isStore;
	assign dataWrData = (idEx.op == STB) ? oper2 : oper1;

endmodule

/* verilog/alu.sv */
`timescale 1ns/100ps

module alu #(
	parameter int dataW = 8
) (
	input logic [dataW-1:0] oper1,
	input logic [dataW-1:0] oper2,
	input cpuPkg::opcodeT op,
	output logic [dataW-1:0] result,
	output logic branchTaken
);
	import cpuPkg::*;

	logic zeroA;
	logic zeroB;

	// branch flags, A rides on oper1 and B on oper2
	assign zeroA = (oper1 == '0);
	assign zeroB = (oper2 == '0);

	always_comb begin
		result = '0;
		case (op)
			// constant passes through for a direct load
			LDCA, LDCB: result = oper1;
			// modulo 2^dataW, no carry kept
			ADDA, ADDB, ADDCA, ADDCB: result = oper1 + oper2;
			SUBA, SUBB, SUBCA: result = oper1 - oper2;
			// B sits on oper2 here, constant on oper1
			SUBCB: result = oper2 - oper1;
			ANDA, ANDB, ANDCA, ANDCB: result = oper1 & oper2;
			ORA, ORB, ORCA, ORCB: result = oper1 | oper2;
			// zero fill both ways
			ASLA: result = oper1 << 1;
			ASRA: result = oper1 >> 1;
			default: result = '0;
		endcase
	end

	always_comb begin
		case (op)
			JMP: branchTaken = 1'b1;
			BAEQ: branchTaken = zeroA;
			BANE: branchTaken = !zeroA;
			// sign bit is the msb
			BAMI: branchTaken = oper1[dataW-1];
			BAPL: branchTaken = !oper1[dataW-1];
			BBEQ: branchTaken = zeroB;
			BBNE: branchTaken = !zeroB;
			BBMI: branchTaken = oper2[dataW-1];
			BBPL: branchTaken = !oper2[dataW-1];
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

/* verilog/ctrlIf.sv */
`timescale 1ns/100ps

interface ctrlIf;
	import cpuPkg::*;

	// hold IF and ID, bubble into EX
	logic stall;
	// taken branch kills the two younger instructions
	logic flushId;
	logic flushEx;

	// opcode sitting in ID
	opcodeT idOp;
	// write target of the instruction in EX, already gated by its valid
	acumCtrlT exAcumCtrl;
	logic exValid;
	// branch or JMP resolved in EX
	logic branchTaken;

	modport ctrl (
		output stall,
		output flushId,
		output flushEx,
		input idOp,
		input exAcumCtrl,
		input exValid,
		input branchTaken
	);

	modport stage (
		input stall,
		input flushId,
		input flushEx,
		output idOp,
		output exAcumCtrl,
		output exValid,
		output branchTaken
	);

endinterface

/* verilog/cpuPkg.sv */
package cpuPkg;

	// instruction word, opcode field on top
	localparam int instrW = 16;

	// opcodes, unknown codes decode as NOP
	typedef enum logic [5:0] {
		NOP   = 6'h00,
		LDA   = 6'h01,
		LDB   = 6'h02,
		LDCA  = 6'h03,
		LDCB  = 6'h04,
		STA   = 6'h05,
		STB   = 6'h06,
		ADDA  = 6'h07,
		ADDB  = 6'h08,
		ADDCA = 6'h09,
		ADDCB = 6'h0A,
		SUBA  = 6'h0B,
		SUBB  = 6'h0C,
		SUBCA = 6'h0D,
		SUBCB = 6'h0E,
		ANDA  = 6'h0F,
		ANDB  = 6'h10,
		ANDCA = 6'h11,
		ANDCB = 6'h12,
		ORA   = 6'h13,
		ORB   = 6'h14,
		ORCA  = 6'h15,
		ORCB  = 6'h16,
		ASLA  = 6'h17,
		ASRA  = 6'h18,
		JMP   = 6'h19,
		BAEQ  = 6'h1A,
		BANE  = 6'h1B,
		BAMI  = 6'h1C,
		BAPL  = 6'h1D,
		BBEQ  = 6'h1E,
		BBNE  = 6'h1F,
		BBMI  = 6'h20,
		BBPL  = 6'h21
	} opcodeT;

	// accumulator write source and target, applied in WB
	typedef enum logic [2:0] {
		noLoad      = 3'd0,
		loadConstA  = 3'd1,
		loadConstB  = 3'd2,
		loadResultA = 3'd3,
		loadResultB = 3'd4,
		loadMemA    = 3'd5,
		loadMemB    = 3'd6
	} acumCtrlT;

	// bit 0 selects A for operand 1, bit 1 selects B for operand 2
	typedef enum logic [1:0] {
		selConstants   = 2'b00,
		selAcumAConstB = 2'b01,
		selConstAAcumB = 2'b10,
		selAcumAB      = 2'b11
	} muxSelT;

	typedef struct packed {
		logic [instrW-1:0] instruction;
		logic [9:0] pc;
	} ifIdT;

	typedef struct packed {
		logic [7:0] acumA;
		logic [7:0] acumB;
		logic [7:0] constant;
		muxSelT muxSel;
		opcodeT op;
		logic [9:0] target;
		acumCtrlT acumCtrl;
		logic isStore;
		logic isLoad;
	} idExT;

	typedef struct packed {
		logic [7:0] result;
		acumCtrlT acumCtrl;
	} exWbT;

endpackage
